/* rtl/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LMR = 4'b0000,
    CMD_REF = 4'b0001,
    CMD_PRE = 4'b0010,
    CMD_ACT = 4'b0011,
    CMD_WR  = 4'b0100,
    CMD_RD  = 4'b0101,
    CMD_NOP = 4'b0111,
    CMD_INH = 4'b1111   // chip deselected
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACT,
    ST_WAIT,
    ST_RD,
    ST_WR,
    ST_PRE,
    ST_REF
  } fsm_state_e;

  typedef enum logic [2:0] {
    IN_WAIT,
    IN_PRE,
    IN_REF,
    IN_DELAY,
    IN_LMR,
    IN_DONE
  } init_state_e;

  // word address is {row, bank, col}
  localparam int ADDR_W = 20;
  localparam int ROW_W  = 11;
  localparam int COL_W  = 8;
  localparam int DATA_W = 16;
  localparam int BE_W   = 2;

  localparam int CAS_LATENCY    = 3;
  localparam int T_RCD          = 3;
  localparam int T_RP           = 2;
  localparam int T_RFC          = 6;
  localparam int T_WR           = 2;
  localparam int INIT_REFRESHES = 8;

  // write burst mode 0, cas latency 3, sequential, burst length 1
  localparam logic [ROW_W-1:0] MODE_WORD = 11'b000_0011_0000;

endpackage

`default_nettype wire

/* rtl/sdram_ifs.sv */
`default_nettype none

// head of the request queue, presented to the command FSM
interface sdram_req_if;
  logic                          valid;
  logic                          rnw;
  logic [sdram_pkg::ADDR_W-1:0]  addr;
  logic [sdram_pkg::BE_W-1:0]    be_n;
  logic [sdram_pkg::DATA_W-1:0]  data;
  logic                          pop;   // drop head on this edge

  modport fifo (
    output valid, rnw, addr, be_n, data,
    input  pop
  );

  modport fsm (
    input  valid, rnw, addr, be_n, data,
    output pop
  );
endinterface

// registered pin command from the FSM to the I/O block
interface sdram_cmd_if;
  sdram_pkg::sdram_cmd_e         cmd;
  logic                          bank;
  logic [sdram_pkg::ROW_W-1:0]   addr;
  logic [sdram_pkg::BE_W-1:0]    dqm;
  logic [sdram_pkg::DATA_W-1:0]  wdata;
  logic                          oe;    // drive dq with wdata

  modport fsm (
    output cmd, bank, addr, dqm, wdata, oe
  );

  modport io (
    input  cmd, bank, addr, dqm, wdata, oe
  );
endinterface

`default_nettype wire

/* rtl/sdram_req_fifo.sv */
`default_nettype none

module sdram_req_fifo #(
  parameter int FIFO_DEPTH = 2
) (
  input  wire                             clk,
  input  wire                             reset_n,
  input  wire                             i_wr,
  input  wire                             i_rnw,
  input  wire [sdram_pkg::ADDR_W-1:0]     i_addr,
  input  wire [sdram_pkg::BE_W-1:0]       i_be_n,
  input  wire [sdram_pkg::DATA_W-1:0]     i_data,
  output logic                            o_full,
  sdram_req_if.fifo                       req
);
  localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
  localparam int ENTRY_W = 1 + sdram_pkg::ADDR_W + sdram_pkg::BE_W + sdram_pkg::DATA_W;

  logic [ENTRY_W-1:0]         mem [FIFO_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           count;
  logic [sdram_pkg::BE_W-1:0] be_n_in;
  logic                       do_wr;
  logic                       do_rd;

  assign o_full    = (count == CNT_W'(FIFO_DEPTH));
  assign req.valid = (count != '0);
  assign {req.rnw, req.addr, req.be_n, req.data} = mem[rd_ptr];

  assign be_n_in = i_rnw ? {sdram_pkg::BE_W{1'b0}} : i_be_n;   // reads take all lanes
  assign do_wr   = i_wr && !o_full;
  assign do_rd   = req.pop && req.valid;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= {i_rnw, i_addr, be_n_in, i_data};
  end

  // host must respect wait-request, FSM only pops a valid head
  fifo_no_overflow : assert property (@(posedge clk) disable iff (!reset_n)
    !(i_wr && o_full) && !(req.pop && !req.valid));

endmodule

`default_nettype wire

/* rtl/sdram_init_seq.sv */
`default_nettype none

module sdram_init_seq (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire                           i_expired,
  output sdram_pkg::sdram_cmd_e         o_init_cmd,
  output logic [sdram_pkg::ROW_W-1:0]   o_init_addr,
  output logic                          o_init_done
);
  localparam int CNT_W = $clog2(sdram_pkg::T_RFC + 1);
  localparam int REF_W = $clog2(sdram_pkg::INIT_REFRESHES + 1);

  sdram_pkg::init_state_e state;
  sdram_pkg::init_state_e next_state;   // where IN_DELAY goes
  logic [CNT_W-1:0]       count;
  logic [REF_W-1:0]       refs;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= sdram_pkg::IN_WAIT;
      next_state  <= sdram_pkg::IN_WAIT;
      o_init_cmd  <= sdram_pkg::CMD_INH;
      o_init_addr <= '1;
      count       <= '0;
      refs        <= '0;
      o_init_done <= 1'b0;
    end
    else
    begin
      o_init_addr <= '1;   // a10 high, precharge all
      case (state)
        sdram_pkg::IN_WAIT:
        begin
          o_init_cmd <= sdram_pkg::CMD_INH;
          if (i_expired)   // power-up wait over
            state <= sdram_pkg::IN_PRE;
        end
        sdram_pkg::IN_PRE:
        begin
          o_init_cmd <= sdram_pkg::CMD_PRE;
          count      <= CNT_W'(sdram_pkg::T_RP);
          next_state <= sdram_pkg::IN_REF;
          state      <= sdram_pkg::IN_DELAY;
        end
        sdram_pkg::IN_REF:
        begin
          o_init_cmd <= sdram_pkg::CMD_REF;
          refs       <= refs + 1'b1;
          count      <= CNT_W'(sdram_pkg::T_RFC);
          state      <= sdram_pkg::IN_DELAY;
          if (refs == REF_W'(sdram_pkg::INIT_REFRESHES - 1))
            next_state <= sdram_pkg::IN_LMR;
          else
            next_state <= sdram_pkg::IN_REF;
        end
        sdram_pkg::IN_DELAY:
        begin
          o_init_cmd <= sdram_pkg::CMD_NOP;
          if (count > 1)
            count <= count - 1'b1;
          else
            state <= next_state;
        end
        sdram_pkg::IN_LMR:
        begin
          o_init_cmd  <= sdram_pkg::CMD_LMR;
          o_init_addr <= sdram_pkg::MODE_WORD;
          count       <= CNT_W'(sdram_pkg::T_RCD);   // covers mode register set time
          next_state  <= sdram_pkg::IN_DONE;
          state       <= sdram_pkg::IN_DELAY;
        end
        sdram_pkg::IN_DONE:
        begin
          o_init_cmd  <= sdram_pkg::CMD_NOP;
          o_init_done <= 1'b1;   // sticky until reset
        end
        default:
          state <= sdram_pkg::IN_WAIT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/sdram_refresh_timer.sv */
`default_nettype none

module sdram_refresh_timer #(
  parameter int INIT_WAIT      = 15600,
  parameter int REFRESH_PERIOD = 780
) (
  input  wire  clk,
  input  wire  reset_n,
  input  wire  i_init_done,
  input  wire  i_refresh_ack,
  output logic o_expired,
  output logic o_refresh_req
);
  localparam int MAX_CNT = (INIT_WAIT > REFRESH_PERIOD) ? INIT_WAIT : REFRESH_PERIOD;
  localparam int CNT_W   = $clog2(MAX_CNT + 1);

  logic [CNT_W-1:0] count;

  assign o_expired = (count == '0);

  // first zero marks end of power-up wait, then one per refresh interval
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      count <= CNT_W'(INIT_WAIT);
    else if (o_expired)
      count <= CNT_W'(REFRESH_PERIOD - 1);
    else
      count <= count - 1'b1;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_refresh_req <= 1'b0;
    else
      o_refresh_req <= (o_expired || o_refresh_req) && !i_refresh_ack && i_init_done;
  end

endmodule

`default_nettype wire

/* rtl/sdram_cmd_fsm.sv */
`default_nettype none

module sdram_cmd_fsm (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire sdram_pkg::sdram_cmd_e    i_init_cmd,
  input  wire [sdram_pkg::ROW_W-1:0]    i_init_addr,
  input  wire                           i_init_done,
  input  wire                           i_refresh_req,
  output logic                          o_refresh_ack,
  sdram_req_if.fsm                      req,
  sdram_cmd_if.fsm                      pins
);
  localparam int CNT_W = $clog2(sdram_pkg::T_RFC + 1);
  localparam int PAD_W = sdram_pkg::ROW_W - sdram_pkg::COL_W;

  sdram_pkg::fsm_state_e         state;
  sdram_pkg::fsm_state_e         next_state;   // target after ST_WAIT
  logic [CNT_W-1:0]              count;
  logic                          accept;
  logic                          active_rnw;
  logic [sdram_pkg::ADDR_W-1:0]  active_addr;
  logic [sdram_pkg::BE_W-1:0]    active_be_n;
  logic [sdram_pkg::DATA_W-1:0]  active_data;

  // refresh wins over a queued access
  assign accept = (state == sdram_pkg::ST_IDLE) && i_init_done && !i_refresh_req && req.valid;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= sdram_pkg::ST_IDLE;
      next_state    <= sdram_pkg::ST_IDLE;
      count         <= '0;
      req.pop       <= 1'b0;
      o_refresh_ack <= 1'b0;
      pins.cmd      <= sdram_pkg::CMD_INH;
      pins.bank     <= 1'b0;
      pins.addr     <= '0;
      pins.dqm      <= '0;
      pins.oe       <= 1'b0;
    end
    else
    begin
      req.pop       <= accept;
      o_refresh_ack <= 1'b0;
      pins.oe       <= 1'b0;
      pins.cmd      <= sdram_pkg::CMD_NOP;
      case (state)
        sdram_pkg::ST_IDLE:
        begin
          if (!i_init_done)
          begin
            pins.cmd  <= i_init_cmd;   // init sequencer owns the pins
            pins.addr <= i_init_addr;
          end
          else if (i_refresh_req)
          begin
            next_state <= sdram_pkg::ST_REF;
            state      <= sdram_pkg::ST_PRE;
          end
          else if (req.valid)
            state <= sdram_pkg::ST_ACT;
        end
        sdram_pkg::ST_ACT:
        begin
          pins.cmd   <= sdram_pkg::CMD_ACT;
          pins.bank  <= active_addr[sdram_pkg::COL_W];
          pins.addr  <= active_addr[sdram_pkg::ADDR_W-1 -: sdram_pkg::ROW_W];
          count      <= CNT_W'(sdram_pkg::T_RCD);
          next_state <= active_rnw ? sdram_pkg::ST_RD : sdram_pkg::ST_WR;
          state      <= sdram_pkg::ST_WAIT;
        end
        sdram_pkg::ST_WAIT:
        begin
          if (count > 1)
            count <= count - 1'b1;
          else
            state <= next_state;
        end
        sdram_pkg::ST_RD, sdram_pkg::ST_WR:
        begin
          pins.cmd   <= active_rnw ? sdram_pkg::CMD_RD : sdram_pkg::CMD_WR;
          pins.oe    <= !active_rnw;
          pins.addr  <= {{PAD_W{1'b0}}, active_addr[sdram_pkg::COL_W-1:0]};   // a10 low
          pins.dqm   <= active_be_n;
          count      <= CNT_W'(sdram_pkg::T_WR);
          next_state <= sdram_pkg::ST_PRE;
          state      <= sdram_pkg::ST_WAIT;
        end
        sdram_pkg::ST_PRE:
        begin
          pins.cmd <= sdram_pkg::CMD_PRE;
          count    <= CNT_W'(sdram_pkg::T_RP);
          state    <= sdram_pkg::ST_WAIT;
          if (next_state == sdram_pkg::ST_REF)
            pins.addr <= '1;   // all banks ahead of refresh
          else
          begin
            pins.addr  <= '0;
            next_state <= sdram_pkg::ST_IDLE;
          end
        end
        sdram_pkg::ST_REF:
        begin
          pins.cmd      <= sdram_pkg::CMD_REF;
          o_refresh_ack <= 1'b1;
          count         <= CNT_W'(sdram_pkg::T_RFC);
          next_state    <= sdram_pkg::ST_IDLE;
          state         <= sdram_pkg::ST_WAIT;
        end
        default:
          state <= sdram_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      active_rnw  <= req.rnw;
      active_addr <= req.addr;
      active_be_n <= req.be_n;
      active_data <= req.data;
    end
    if (state == sdram_pkg::ST_WR)
      pins.wdata <= active_data;
  end

  // every open row is closed before the next activate
  act_after_pre : assert property (@(posedge clk) disable iff (!reset_n)
    pins.cmd == sdram_pkg::CMD_ACT |=>
      (pins.cmd != sdram_pkg::CMD_ACT) until (pins.cmd == sdram_pkg::CMD_PRE));

endmodule

`default_nettype wire

/* rtl/sdram_io.sv */
`default_nettype none

module sdram_io (
  input  wire                            clk,
  input  wire                            reset_n,
  sdram_cmd_if.io                        pins,
  output logic [3:0]                     o_zs_cmd,
  output logic [sdram_pkg::ROW_W-1:0]    o_zs_addr,
  output logic                           o_zs_ba,
  output logic [sdram_pkg::BE_W-1:0]     o_zs_dqm,
  inout  wire  [sdram_pkg::DATA_W-1:0]   io_zs_dq,
  output logic [sdram_pkg::DATA_W-1:0]   o_za_data,
  output logic                           o_za_valid
);
  logic [sdram_pkg::CAS_LATENCY-1:0] rd_valid;   // one bit per read in flight

  assign o_zs_cmd  = pins.cmd;
  assign o_zs_addr = pins.addr;
  assign o_zs_ba   = pins.bank;
  assign o_zs_dqm  = pins.dqm;
  assign io_zs_dq  = pins.oe ? pins.wdata : {sdram_pkg::DATA_W{1'bz}};

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_valid   <= '0;
      o_za_valid <= 1'b0;
    end
    else
    begin
      rd_valid   <= {rd_valid[sdram_pkg::CAS_LATENCY-2:0], pins.cmd == sdram_pkg::CMD_RD};
      o_za_valid <= rd_valid[sdram_pkg::CAS_LATENCY-1];   // lines up with o_za_data
    end
  end

  always_ff @(posedge clk)
    o_za_data <= io_zs_dq;   // sampled every edge

  // no write drive while the device returns read data
  no_dq_contention : assert property (@(posedge clk) disable iff (!reset_n)
    !(pins.oe && rd_valid[sdram_pkg::CAS_LATENCY-1]));

endmodule

`default_nettype wire

/* rtl/sdram_ctrl.sv */
`default_nettype none

module sdram_ctrl #(
  parameter int INIT_WAIT      = 15600,
  parameter int REFRESH_PERIOD = 780,
  parameter int FIFO_DEPTH     = 2
) (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire  [sdram_pkg::ADDR_W-1:0]   i_az_addr,
  input  wire  [sdram_pkg::BE_W-1:0]     i_az_be_n,
  input  wire  [sdram_pkg::DATA_W-1:0]   i_az_data,
  input  wire                            i_az_rd_n,
  input  wire                            i_az_wr_n,
  output logic                           o_az_waitrequest,
  output logic [sdram_pkg::DATA_W-1:0]   o_za_data,
  output logic                           o_za_valid,
  output logic [sdram_pkg::ROW_W-1:0]    o_zs_addr,
  output logic                           o_zs_ba,
  output logic                           o_zs_cs_n,
  output logic                           o_zs_ras_n,
  output logic                           o_zs_cas_n,
  output logic                           o_zs_we_n,
  output logic                           o_zs_cke,
  output logic [sdram_pkg::BE_W-1:0]     o_zs_dqm,
  inout  wire  [sdram_pkg::DATA_W-1:0]   io_zs_dq
);
  sdram_pkg::sdram_cmd_e        init_cmd;
  logic [sdram_pkg::ROW_W-1:0]  init_addr;
  logic                         init_done;
  logic                         expired;
  logic                         refresh_req;
  logic                         refresh_ack;
  logic [3:0]                   zs_cmd;
  logic                         az_accept;

  sdram_req_if req_if ();
  sdram_cmd_if cmd_if ();

  assign az_accept = (!i_az_rd_n || !i_az_wr_n) && !o_az_waitrequest;
  assign {o_zs_cs_n, o_zs_ras_n, o_zs_cas_n, o_zs_we_n} = zs_cmd;
  assign o_zs_cke  = 1'b1;

  sdram_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
    .clk(clk), .reset_n(reset_n), .i_wr(az_accept), .i_rnw(i_az_wr_n),
    .i_addr(i_az_addr), .i_be_n(i_az_be_n), .i_data(i_az_data),
    .o_full(o_az_waitrequest), .req(req_if.fifo));

  sdram_refresh_timer #(.INIT_WAIT(INIT_WAIT), .REFRESH_PERIOD(REFRESH_PERIOD)) timer_i (
    .clk(clk), .reset_n(reset_n), .i_init_done(init_done), .i_refresh_ack(refresh_ack),
    .o_expired(expired), .o_refresh_req(refresh_req));

  sdram_init_seq init_i (
    .clk(clk), .reset_n(reset_n), .i_expired(expired), .o_init_cmd(init_cmd),
    .o_init_addr(init_addr), .o_init_done(init_done));

  sdram_cmd_fsm fsm_i (
    .clk(clk), .reset_n(reset_n), .i_init_cmd(init_cmd), .i_init_addr(init_addr),
    .i_init_done(init_done), .i_refresh_req(refresh_req), .o_refresh_ack(refresh_ack),
    .req(req_if.fsm), .pins(cmd_if.fsm));

  sdram_io io_i (
    .clk(clk), .reset_n(reset_n), .pins(cmd_if.io), .o_zs_cmd(zs_cmd),
    .o_zs_addr(o_zs_addr), .o_zs_ba(o_zs_ba), .o_zs_dqm(o_zs_dqm), .io_zs_dq(io_zs_dq),
    .o_za_data(o_za_data), .o_za_valid(o_za_valid));

endmodule

`default_nettype wire

/* verification/sdram_mem_model.sv */
`default_nettype none

module sdram_mem_model (
  input  wire        clk,
  input  wire        i_cs_n,
  input  wire        i_ras_n,
  input  wire        i_cas_n,
  input  wire        i_we_n,
  input  wire [10:0] i_addr,
  input  wire        i_ba,
  input  wire [1:0]  i_dqm,
  inout  wire [15:0] io_dq
);
  logic [15:0] mem [int];
  logic [10:0] open_row [2];
  logic [1:0]  rd_pipe;       // read seen one and two edges ago
  logic [19:0] rd_addr [2];
  logic [15:0] dq_out;
  logic        dq_en;

  assign io_dq = dq_en ? dq_out : 16'hzzzz;

  initial
  begin
    rd_pipe     = '0;
    dq_en       = 1'b0;
    dq_out      = '0;
    open_row[0] = '0;
    open_row[1] = '0;
  end

  // unwritten words return a pattern of the full address
  function automatic logic [15:0] read_word(input logic [19:0] a);
    if (mem.exists(a))
      return mem[a];
    return a[15:0] ^ {a[19:16], a[19:8]};
  endfunction

  always @(posedge clk)
  begin
    logic [3:0]  cmd;
    logic [19:0] a;
    logic [15:0] old;
    cmd = {i_cs_n, i_ras_n, i_cas_n, i_we_n};
    a   = {open_row[i_ba], i_ba, i_addr[7:0]};
    if (cmd == sdram_pkg::CMD_ACT)
      open_row[i_ba] <= i_addr;
    if (cmd == sdram_pkg::CMD_WR)
    begin
      old    = read_word(a);
      mem[a] = {i_dqm[1] ? old[15:8] : io_dq[15:8], i_dqm[0] ? old[7:0] : io_dq[7:0]};
    end
    rd_pipe    <= {rd_pipe[0], cmd == sdram_pkg::CMD_RD};
    rd_addr[0] <= a;
    rd_addr[1] <= rd_addr[0];
    // drive for one cycle, cas latency 3
    dq_en  <= rd_pipe[1];
    dq_out <= read_word(rd_addr[1]);
  end

endmodule

`default_nettype wire

/* verification/sdram_checker.sv */
`default_nettype none

module sdram_checker #(
  parameter int REFRESH_PERIOD = 300
) (
  input  wire        clk,
  input  wire        reset_n,
  input  wire [19:0] i_az_addr,
  input  wire [1:0]  i_az_be_n,
  input  wire        i_az_rd_n,
  input  wire        i_az_wr_n,
  input  wire        i_az_waitrequest,
  input  wire [15:0] i_exp_data,
  input  wire [3:0]  i_cmd,
  input  wire [10:0] i_addr,
  input  wire        i_ba,
  input  wire        i_cke,
  input  wire [1:0]  i_dqm,
  input  wire [15:0] i_za_data,
  input  wire        i_za_valid,
  input  wire        i_done,
  output int         o_fail_count,
  output logic       o_finished
);
  logic [19:0] ent_addr [64];
  logic [1:0]  ent_be_n [64];
  logic        ent_rnw [64];
  logic [15:0] ent_exp [64];
  int          ent_err [64];
  int          acc_q [$];   // accesses not yet issued
  int          rd_q [$];    // reads awaiting data
  int          n_entries = 0;
  int          n_reads = 0;
  int          init_idx = 0;
  int          init_err = 0;
  int          gen_err = 0;
  int          refs = 0;
  int          cycles_after_init = 0;
  int          wait_cycles = 0;
  int          valid_count = 0;
  int          passed = 0;
  int          failed = 0;
  logic        init_seen = 1'b0;
  logic        row_open = 1'b0;
  logic        last_pre_all = 1'b0;

  initial
  begin
    o_fail_count = 0;
    o_finished   = 1'b0;
  end

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got,
                             input int idx);
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    if (idx >= 0)
      ent_err[idx]++;
    else
      gen_err++;
  endtask

  task automatic score_test(input string what, input logic ok);
    if (ok)
    begin
      passed++;
      $display("test %s: ok", what);
    end
    else
    begin
      failed++;
      $display("test %s: FAILED", what);
    end
  endtask

  always @(posedge clk)
  begin
    sdram_pkg::sdram_cmd_e cmd;
    int idx;
    cmd = sdram_pkg::sdram_cmd_e'(i_cmd);
    if (reset_n && !o_finished)
    begin
      if ((!i_az_rd_n || !i_az_wr_n) && !i_az_waitrequest)
      begin
        ent_addr[n_entries] = i_az_addr;
        ent_be_n[n_entries] = i_az_be_n;
        ent_rnw[n_entries]  = i_az_wr_n;
        ent_exp[n_entries]  = i_exp_data;
        ent_err[n_entries]  = 0;
        acc_q.push_back(n_entries);
        if (i_az_wr_n)
        begin
          rd_q.push_back(n_entries);
          n_reads++;
        end
        n_entries++;
      end
      if (i_az_waitrequest)
        wait_cycles++;
      if (i_cke !== 1'b1)
        value_error("o_zs_cke", 32'd1, i_cke, -1);   // clock enable stays high

      if (!init_seen)
      begin
        if (cmd == sdram_pkg::CMD_ACT)
        begin
          $display("error at %0t: activate issued before load mode", $time);
          init_err++;
        end
        else if (cmd != sdram_pkg::CMD_NOP && cmd != sdram_pkg::CMD_INH)
        begin
          if (init_idx == 0 && !(cmd == sdram_pkg::CMD_PRE && i_addr[10]))
            value_error("precharge all {cmd, o_zs_addr}", {sdram_pkg::CMD_PRE, 11'h400},
                        {cmd, i_addr}, -1);
          else if (init_idx >= 1 && init_idx <= sdram_pkg::INIT_REFRESHES &&
                   cmd != sdram_pkg::CMD_REF)
            value_error("init refresh cmd", sdram_pkg::CMD_REF, cmd, -1);
          else if (init_idx == sdram_pkg::INIT_REFRESHES + 1 &&
                   !(cmd == sdram_pkg::CMD_LMR && i_addr == sdram_pkg::MODE_WORD))
            value_error("load mode {cmd, o_zs_addr}", {sdram_pkg::CMD_LMR, sdram_pkg::MODE_WORD},
                        {cmd, i_addr}, -1);
          init_idx++;
          if (cmd == sdram_pkg::CMD_LMR)
            init_seen = 1'b1;
        end
      end
      else
      begin
        cycles_after_init++;
        case (cmd)
          sdram_pkg::CMD_ACT:
          begin
            if (row_open)
            begin
              $display("error at %0t: activate while a row is still open", $time);
              gen_err++;
            end
            if (acc_q.size() == 0)
            begin
              $display("error at %0t: activate with no access queued", $time);
              gen_err++;
            end
            else
            begin
              idx = acc_q[0];
              if (i_addr != ent_addr[idx][19:9])
                value_error("act row o_zs_addr", ent_addr[idx][19:9], i_addr, idx);
              if (i_ba != ent_addr[idx][8])
                value_error("act o_zs_ba", ent_addr[idx][8], i_ba, idx);
            end
            row_open = 1'b1;
          end
          sdram_pkg::CMD_RD, sdram_pkg::CMD_WR:
          begin
            if (acc_q.size() == 0)
            begin
              $display("error at %0t: read or write with no access queued", $time);
              gen_err++;
            end
            else
            begin
              idx = acc_q.pop_front();
              if (!row_open)
              begin
                $display("error at %0t: column command without an open row", $time);
                ent_err[idx]++;
              end
              if ((cmd == sdram_pkg::CMD_RD) != ent_rnw[idx])
                value_error("cmd is read", ent_rnw[idx], cmd == sdram_pkg::CMD_RD, idx);
              if (i_addr != {3'b000, ent_addr[idx][7:0]})
                value_error("column o_zs_addr", {3'b000, ent_addr[idx][7:0]}, i_addr, idx);
              if (i_ba != ent_addr[idx][8])
                value_error("column o_zs_ba", ent_addr[idx][8], i_ba, idx);
              if (i_dqm != (ent_rnw[idx] ? 2'b00 : ent_be_n[idx]))
                value_error("o_zs_dqm", ent_rnw[idx] ? 2'b00 : ent_be_n[idx], i_dqm, idx);
              if (!ent_rnw[idx])
                score_test($sformatf("%0d write %h", idx, ent_addr[idx]), ent_err[idx] == 0);
            end
          end
          sdram_pkg::CMD_PRE:
            row_open = 1'b0;
          sdram_pkg::CMD_REF:
          begin
            refs++;
            if (row_open || !last_pre_all)
            begin
              $display("error at %0t: refresh without a preceding precharge all", $time);
              gen_err++;
            end
          end
          default:
            ;
        endcase
        if (cmd != sdram_pkg::CMD_NOP && cmd != sdram_pkg::CMD_INH)
          last_pre_all = (cmd == sdram_pkg::CMD_PRE) && i_addr[10];
      end

      if (i_za_valid)
      begin
        valid_count++;
        if (rd_q.size() == 0)
        begin
          $display("error at %0t: read data returned with no read outstanding", $time);
          gen_err++;
        end
        else
        begin
          idx = rd_q.pop_front();
          if (i_za_data != ent_exp[idx])
            value_error("o_za_data", ent_exp[idx], i_za_data, idx);
          score_test($sformatf("%0d read %h", idx, ent_addr[idx]), ent_err[idx] == 0);
        end
      end
    end
  end

  // closing checks once the stimulus is over
  always @(posedge i_done)
  begin
    score_test("init order", init_seen && init_err == 0 &&
               init_idx == sdram_pkg::INIT_REFRESHES + 2);
    score_test("refresh rate", refs >= cycles_after_init / REFRESH_PERIOD - 1 && refs > 0);
    score_test("back-pressure", wait_cycles > 0);
    score_test("response count", valid_count == n_reads && rd_q.size() == 0 &&
               acc_q.size() == 0);
    score_test("pin protocol", gen_err == 0);
    $display("checks finished: %0d passed, %0d failed", passed, failed);
    o_fail_count = failed;
    o_finished   = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/sdram_tb.sv */
`default_nettype none

module sdram_tb;
  localparam int INIT_WAIT      = 200;
  localparam int REFRESH_PERIOD = 300;
  localparam int FIFO_DEPTH     = 2;
  localparam int CLK_PERIOD     = 40;
  localparam int N_ENTRIES      = 12;
  // init wait, 40 cycles per entry, two refresh periods of idle, margin
  localparam int TIMEOUT = (INIT_WAIT + 40 * N_ENTRIES + 2 * REFRESH_PERIOD + 200) * CLK_PERIOD;

  logic        clk;
  logic        reset_n;
  logic [19:0] az_addr;
  logic [1:0]  az_be_n;
  logic [15:0] az_data;
  logic        az_rd_n;
  logic        az_wr_n;
  logic [15:0] exp_data;
  logic        done;
  wire         az_waitrequest;
  wire  [15:0] za_data;
  wire         za_valid;
  wire  [10:0] zs_addr;
  wire         zs_ba;
  wire         zs_cs_n;
  wire         zs_ras_n;
  wire         zs_cas_n;
  wire         zs_we_n;
  wire         zs_cke;
  wire  [1:0]  zs_dqm;
  wire  [15:0] zs_dq;
  wire         chk_finished;
  int          fail_count;

  // {rnw, addr, be_n, wdata, expected read data}
  logic [54:0] table_entry [N_ENTRIES];
  int          seed;
  int          gap;
  int          n_reads;
  int          valid_seen;

  sdram_ctrl #(
    .INIT_WAIT(INIT_WAIT),
    .REFRESH_PERIOD(REFRESH_PERIOD),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut_i (
    .clk(clk), .reset_n(reset_n), .i_az_addr(az_addr), .i_az_be_n(az_be_n),
    .i_az_data(az_data), .i_az_rd_n(az_rd_n), .i_az_wr_n(az_wr_n),
    .o_az_waitrequest(az_waitrequest), .o_za_data(za_data), .o_za_valid(za_valid),
    .o_zs_addr(zs_addr), .o_zs_ba(zs_ba), .o_zs_cs_n(zs_cs_n), .o_zs_ras_n(zs_ras_n),
    .o_zs_cas_n(zs_cas_n), .o_zs_we_n(zs_we_n), .o_zs_cke(zs_cke), .o_zs_dqm(zs_dqm),
    .io_zs_dq(zs_dq));

  sdram_mem_model mem_i (
    .clk(clk), .i_cs_n(zs_cs_n), .i_ras_n(zs_ras_n), .i_cas_n(zs_cas_n),
    .i_we_n(zs_we_n), .i_addr(zs_addr), .i_ba(zs_ba), .i_dqm(zs_dqm), .io_dq(zs_dq));

  sdram_checker #(.REFRESH_PERIOD(REFRESH_PERIOD)) chk_i (
    .clk(clk), .reset_n(reset_n), .i_az_addr(az_addr), .i_az_be_n(az_be_n),
    .i_az_rd_n(az_rd_n), .i_az_wr_n(az_wr_n), .i_az_waitrequest(az_waitrequest),
    .i_exp_data(exp_data), .i_cmd({zs_cs_n, zs_ras_n, zs_cas_n, zs_we_n}),
    .i_addr(zs_addr), .i_ba(zs_ba), .i_cke(zs_cke), .i_dqm(zs_dqm),
    .i_za_data(za_data), .i_za_valid(za_valid), .i_done(done),
    .o_fail_count(fail_count), .o_finished(chk_finished));

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk)
  begin
    if (reset_n && za_valid)
      valid_seen <= valid_seen + 1;
  end

  initial
  begin
    // bank is addr bit 8
    table_entry[0]  = {1'b0, 20'h00010, 2'b00, 16'h1234, 16'h0000};
    table_entry[1]  = {1'b0, 20'h12345, 2'b00, 16'hABCD, 16'h0000};
    table_entry[2]  = {1'b1, 20'h00010, 2'b00, 16'h0000, 16'h1234};
    table_entry[3]  = {1'b0, 20'h00010, 2'b01, 16'h55AA, 16'h0000};   // low byte kept
    table_entry[4]  = {1'b1, 20'h00010, 2'b00, 16'h0000, 16'h5534};
    table_entry[5]  = {1'b0, 20'h12345, 2'b10, 16'h0F0F, 16'h0000};   // high byte kept
    table_entry[6]  = {1'b1, 20'h12345, 2'b00, 16'h0000, 16'hAB0F};
    table_entry[7]  = {1'b0, 20'hFFFFF, 2'b00, 16'hCAFE, 16'h0000};
    table_entry[8]  = {1'b1, 20'hFFFFF, 2'b00, 16'h0000, 16'hCAFE};
    table_entry[9]  = {1'b1, 20'h12345, 2'b00, 16'h0000, 16'hAB0F};
    table_entry[10] = {1'b0, 20'h00010, 2'b11, 16'h0000, 16'h0000};   // fully masked
    table_entry[11] = {1'b1, 20'h00010, 2'b00, 16'h0000, 16'h5534};

    clk        = 1'b0;
    reset_n    = 1'b0;
    az_addr    = '0;
    az_be_n    = '0;
    az_data    = '0;
    az_rd_n    = 1'b1;
    az_wr_n    = 1'b1;
    exp_data   = '0;
    done       = 1'b0;
    valid_seen = 0;
    n_reads    = 0;
    seed       = 26;

    repeat (4) @(posedge clk);
    #5 reset_n = 1'b1;

    for (int i = 0; i < N_ENTRIES; i++)
    begin
      @(posedge clk);
      #5;
      az_rd_n  = !table_entry[i][54];
      az_wr_n  = table_entry[i][54];
      az_addr  = table_entry[i][53:34];
      az_be_n  = table_entry[i][33:32];
      az_data  = table_entry[i][31:16];
      exp_data = table_entry[i][15:0];
      if (table_entry[i][54])
        n_reads++;
      do
        @(posedge clk);
      while (az_waitrequest);   // held until accepted
      #5;
      az_rd_n = 1'b1;
      az_wr_n = 1'b1;
      // odd entries may pause and even ones go back to back
      gap = (i % 2) ? ($unsigned($random(seed)) % 3) : 0;
      repeat (gap) @(posedge clk);
    end

    wait (valid_seen == n_reads);
    repeat (2 * REFRESH_PERIOD) @(posedge clk);
    done = 1'b1;
    wait (chk_finished);
    #1;
    if (fail_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    #TIMEOUT;
    $display("watchdog expired after %0d time units, run did not complete", TIMEOUT);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/sdram_pkg.sv
rtl/sdram_ifs.sv
rtl/sdram_req_fifo.sv
rtl/sdram_init_seq.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_cmd_fsm.sv
rtl/sdram_io.sv
rtl/sdram_ctrl.sv
verification/sdram_mem_model.sv
verification/sdram_checker.sv
verification/sdram_tb.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - files:
      - rtl/sdram_pkg.sv
      - rtl/sdram_ifs.sv
      - rtl/sdram_req_fifo.sv
      - rtl/sdram_init_seq.sv
      - rtl/sdram_refresh_timer.sv
      - rtl/sdram_cmd_fsm.sv
      - rtl/sdram_io.sv
      - rtl/sdram_ctrl.sv
  - target: test
    files:
      - verification/sdram_mem_model.sv
      - verification/sdram_checker.sv
      - verification/sdram_tb.sv
